// File: l2_defines.svh
/*
 * L2 memory subsystem parameters
 * Data path widths, bank geometry, the two address windows and FIFO depth
 */
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// APB data path
`define L2_ADDR_W 32
`define L2_DATA_W 32
`define L2_STRB_W 4

// Bank geometry
`define L2_NUM_BANKS 2
`define L2_BANK_ROWS 512
`define L2_ROW_W 9

// Both windows alias the same words
`define L2_WIN_SIZE 32'h1000
`define L2_INTERL_BASE 32'h0000_0000
`define L2_NONINTERL_BASE 32'h0000_1000

// Request and response buffering
`define L2_FIFO_DEPTH 2

`endif

// File: l2_pkg.sv
/*
 * L2 memory subsystem types
 * APB4 completer request and response, plus the internal bank
 * request and response payloads
 */
`include "l2_defines.svh"

package l2_pkg;

  // APB4 requester side
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`L2_ADDR_W-1:0] paddr;
    logic [`L2_DATA_W-1:0] pwdata;
    logic [`L2_STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [`L2_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // One word access to a single bank row
  typedef struct packed {
    logic                  we;
    logic                  bank;
    logic [`L2_ROW_W-1:0]  row;
    logic [`L2_DATA_W-1:0] wdata;
    logic [`L2_STRB_W-1:0] strb;
  } l2_req_t;

  // Prior row contents
  typedef struct packed {
    logic [`L2_DATA_W-1:0] rdata;
  } l2_rsp_t;

endpackage

// File: l2_apb_frontend.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

/*
 * APB front end of the L2 memory
 * Maps the interleaved and non-interleaved windows onto bank and row,
 * keeps one transfer outstanding and completes it with the returned word,
 * or at once with PSLVERR when the address hits no window
 */
module l2_apb_frontend (
  input  logic             clk_i,
  input  logic             reset_i,
  input  l2_pkg::apb_req_t apb_req_i,
  output l2_pkg::apb_rsp_t apb_rsp_o,
  output l2_pkg::l2_req_t  req_o,
  output logic             req_valid_o,
  input  logic             req_ready_i,
  input  l2_pkg::l2_rsp_t  rsp_i,
  input  logic             rsp_valid_i,
  output logic             rsp_ready_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [`L2_ROW_W:0] word_idx;
  logic               in_interl;
  logic               in_noninterl;
  logic               access;

  assign access   = apb_req_i.psel & apb_req_i.penable;
  assign word_idx = apb_req_i.paddr[`L2_ROW_W+2:2];

  assign in_interl = (apb_req_i.paddr >= `L2_INTERL_BASE) &&
                     (apb_req_i.paddr < (`L2_INTERL_BASE + `L2_WIN_SIZE));
  assign in_noninterl = (apb_req_i.paddr >= `L2_NONINTERL_BASE) &&
                        (apb_req_i.paddr < (`L2_NONINTERL_BASE + `L2_WIN_SIZE));

  // APB fields stay stable until pready, so the payload is built on the fly
  always_comb begin
    req_o.we    = apb_req_i.pwrite;
    req_o.wdata = apb_req_i.pwdata;
    req_o.strb  = apb_req_i.pstrb;
    if (in_interl) begin
      // Consecutive words alternate banks
      req_o.bank = word_idx[0];
      req_o.row  = word_idx[`L2_ROW_W:1];
    end else begin
      // Each bank fills one half
      req_o.bank = word_idx[`L2_ROW_W];
      req_o.row  = word_idx[`L2_ROW_W-1:0];
    end
  end

  always_comb begin
    state_d     = state_q;
    req_valid_o = 1'b0;
    rsp_ready_o = 1'b0;
    apb_rsp_o   = '0;
    case (state_q)
      ST_IDLE: begin
        if (access) begin
          if (!(in_interl || in_noninterl)) begin
            apb_rsp_o.pready  = 1'b1;
            apb_rsp_o.pslverr = 1'b1;
          end else begin
            req_valid_o = 1'b1;
            state_d     = req_ready_i ? ST_WAIT : ST_ISSUE;
          end
        end
      end
      ST_ISSUE: begin
        // Request FIFO was full on the first access cycle
        req_valid_o = 1'b1;
        if (req_ready_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        rsp_ready_o = 1'b1;
        if (rsp_valid_i) begin
          apb_rsp_o.pready = 1'b1;
          // Old word returned for writes is dropped
          apb_rsp_o.prdata = apb_req_i.pwrite ? '0 : rsp_i.rdata;
          state_d          = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: l2_fifo.sv
`timescale 1ns/1ps

/*
 * Synchronous FIFO with a type-parameterized payload
 * Circular buffer with valid/ready on both sides, accepts a push
 * while full when the head is popped in the same cycle
 */
module l2_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full        = (count_q == CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign in_ready_o  = ~full | out_ready_i;
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;
  assign out_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

endmodule

// File: l2_bank_array.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

/*
 * L2 bank array
 * Word-wide banks with byte-strobed writes; every request returns
 * the prior row contents through a registered, stallable response
 */
module l2_bank_array (
  input  logic            clk_i,
  input  logic            reset_i,
  input  l2_pkg::l2_req_t req_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  output l2_pkg::l2_rsp_t rsp_o,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i
);

  logic [`L2_DATA_W-1:0] mem_q [`L2_NUM_BANKS][`L2_BANK_ROWS];
  logic                  rsp_valid_q;
  logic                  accept;

  // Output register free or draining this cycle
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;
  assign rsp_valid_o = rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Read before write, so a write also returns the old word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_o.rdata <= mem_q[req_i.bank][req_i.row];
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && req_i.we) begin
      for (int b = 0; b < `L2_STRB_W; b++) begin
        if (req_i.strb[b]) begin
          mem_q[req_i.bank][req_i.row][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: l2_subsys_top.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

/*
 * L2 memory subsystem
 * APB front end, request FIFO, bank array and response FIFO in a loop
 */
module l2_subsys_top (
  input  logic             clk_i,
  input  logic             reset_i,
  input  l2_pkg::apb_req_t apb_req_i,
  output l2_pkg::apb_rsp_t apb_rsp_o
);

  import l2_pkg::*;

  // Front end to request FIFO
  l2_req_t fe_req;
  logic    fe_req_valid;
  logic    fe_req_ready;

  // Request FIFO to banks
  l2_req_t bank_req;
  logic    bank_req_valid;
  logic    bank_req_ready;

  // Banks to response FIFO
  l2_rsp_t bank_rsp;
  logic    bank_rsp_valid;
  logic    bank_rsp_ready;

  // Response FIFO to front end
  l2_rsp_t fe_rsp;
  logic    fe_rsp_valid;
  logic    fe_rsp_ready;

  l2_apb_frontend u_frontend (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .apb_req_i   ( apb_req_i    ),
    .apb_rsp_o   ( apb_rsp_o    ),
    .req_o       ( fe_req       ),
    .req_valid_o ( fe_req_valid ),
    .req_ready_i ( fe_req_ready ),
    .rsp_i       ( fe_rsp       ),
    .rsp_valid_i ( fe_rsp_valid ),
    .rsp_ready_o ( fe_rsp_ready )
  );

  l2_fifo #(
    .payload_t ( l2_req_t       ),
    .DEPTH     ( `L2_FIFO_DEPTH )
  ) u_req_fifo (
    .clk_i       ( clk_i          ),
    .reset_i     ( reset_i        ),
    .in_i        ( fe_req         ),
    .in_valid_i  ( fe_req_valid   ),
    .in_ready_o  ( fe_req_ready   ),
    .out_o       ( bank_req       ),
    .out_valid_o ( bank_req_valid ),
    .out_ready_i ( bank_req_ready )
  );

  l2_bank_array u_banks (
    .clk_i       ( clk_i          ),
    .reset_i     ( reset_i        ),
    .req_i       ( bank_req       ),
    .req_valid_i ( bank_req_valid ),
    .req_ready_o ( bank_req_ready ),
    .rsp_o       ( bank_rsp       ),
    .rsp_valid_o ( bank_rsp_valid ),
    .rsp_ready_i ( bank_rsp_ready )
  );

  l2_fifo #(
    .payload_t ( l2_rsp_t       ),
    .DEPTH     ( `L2_FIFO_DEPTH )
  ) u_rsp_fifo (
    .clk_i       ( clk_i          ),
    .reset_i     ( reset_i        ),
    .in_i        ( bank_rsp       ),
    .in_valid_i  ( bank_rsp_valid ),
    .in_ready_o  ( bank_rsp_ready ),
    .out_o       ( fe_rsp         ),
    .out_valid_o ( fe_rsp_valid   ),
    .out_ready_i ( fe_rsp_ready   )
  );

endmodule

// File: l2_sva.sv
`timescale 1ns/1ps

/*
 * APB4 protocol checks for the L2 subsystem port
 * Bound to the top level
 */
module l2_sva (
  input logic             clk_i,
  input logic             reset_i,
  input l2_pkg::apb_req_t apb_req_i,
  input l2_pkg::apb_rsp_t apb_rsp_i
);

  int fail_count = 0;

  property p_ready_in_access;
    @(posedge clk_i) disable iff (reset_i)
      apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable);
  endproperty

  property p_err_with_ready;
    @(posedge clk_i) disable iff (reset_i)
      apb_rsp_i.pslverr |-> apb_rsp_i.pready;
  endproperty

  // Request held from setup until the completer is ready
  property p_req_stable;
    @(posedge clk_i) disable iff (reset_i)
      (apb_req_i.psel && !apb_rsp_i.pready) |=>
        (apb_req_i.psel && $stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite) &&
         $stable(apb_req_i.pwdata) && $stable(apb_req_i.pstrb));
  endproperty

  a_ready_in_access: assert property (p_ready_in_access) else begin
    fail_count++;
    $error("pready outside an access phase");
  end

  a_err_with_ready: assert property (p_err_with_ready) else begin
    fail_count++;
    $error("pslverr without pready");
  end

  a_req_stable: assert property (p_req_stable) else begin
    fail_count++;
    $error("request changed before pready");
  end

endmodule

bind l2_subsys_top l2_sva u_sva (
  .clk_i     ( clk_i     ),
  .reset_i   ( reset_i   ),
  .apb_req_i ( apb_req_i ),
  .apb_rsp_i ( apb_rsp_o )
);

// File: tb_l2_subsys.sv
`timescale 1ns/1ps
`include "l2_defines.svh"

/*
 * Testbench for the L2 memory subsystem
 * Directed and random APB accesses through both windows, checked
 * against a two-bank reference model
 */
module tb_l2_subsys;

  import l2_pkg::*;

  localparam int DIRECTED_TXN = 40;
  localparam int RANDOM_TXN   = 200;
  localparam int TOTAL_TXN    = DIRECTED_TXN + RANDOM_TXN;

  // One outstanding expectation; known marks the bytes worth comparing
  typedef struct packed {
    logic [`L2_ADDR_W-1:0] addr;
    logic [`L2_DATA_W-1:0] prdata;
    logic [`L2_STRB_W-1:0] known;
    logic                  pslverr;
  } expect_t;

  logic     clk_i;
  logic     reset_i;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  logic [`L2_DATA_W-1:0] ref_mem [`L2_NUM_BANKS][`L2_BANK_ROWS];
  expect_t               exp_q [$];
  logic [`L2_ADDR_W-1:0] written_q [$];
  integer                seed;
  int                    checks = 0;
  int                    data_errors = 0;
  int                    slverr_errors = 0;
  int                    other_errors = 0;

  l2_subsys_top dut (
    .clk_i     ( clk_i   ),
    .reset_i   ( reset_i ),
    .apb_req_i ( apb_req ),
    .apb_rsp_o ( apb_rsp )
  );

  always #5 clk_i = ~clk_i;

  // Two-bank model with the window decode
  function automatic expect_t ref_access(input logic [`L2_ADDR_W-1:0] addr,
                                         input logic                  we,
                                         input logic [`L2_DATA_W-1:0] wdata,
                                         input logic [`L2_STRB_W-1:0] strb);
    expect_t              e;
    logic [9:0]           widx;
    logic                 bank;
    logic [`L2_ROW_W-1:0] row;
    logic                 hit;
    e      = '0;
    e.addr = addr;
    widx   = addr[11:2];
    hit    = 1'b1;
    bank   = 1'b0;
    row    = '0;
    if (addr >= `L2_INTERL_BASE && addr < `L2_INTERL_BASE + `L2_WIN_SIZE) begin
      bank = widx[0];
      row  = widx[9:1];
    end else if (addr >= `L2_NONINTERL_BASE &&
                 addr < `L2_NONINTERL_BASE + `L2_WIN_SIZE) begin
      bank = widx[9];
      row  = widx[8:0];
    end else begin
      hit = 1'b0;
    end
    if (!hit) begin
      // Decode error reads as zero
      e.pslverr = 1'b1;
      e.known   = '1;
    end else if (we) begin
      for (int b = 0; b < `L2_STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[bank][row][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end else begin
      e.prdata = ref_mem[bank][row];
      for (int b = 0; b < `L2_STRB_W; b++) begin
        e.known[b] = (^ref_mem[bank][row][8*b +: 8] !== 1'bx);
      end
    end
    return e;
  endfunction

  function automatic logic [`L2_ADDR_W-1:0] interl_addr(input logic bank,
                                                        input logic [`L2_ROW_W-1:0] row);
    return `L2_INTERL_BASE + {row, bank, 2'b00};
  endfunction

  function automatic logic [`L2_ADDR_W-1:0] noninterl_addr(input logic bank,
                                                           input logic [`L2_ROW_W-1:0] row);
    return `L2_NONINTERL_BASE + {bank, row, 2'b00};
  endfunction

  task automatic apb_xfer(input logic [`L2_ADDR_W-1:0] addr, input logic we,
                          input logic [`L2_DATA_W-1:0] wdata,
                          input logic [`L2_STRB_W-1:0] strb);
    expect_t e;
    e = ref_access(addr, we, wdata, strb);
    exp_q.push_back(e);
    if (we && !e.pslverr) begin
      written_q.push_back(addr);
    end
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= we;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    apb_req.pstrb   <= strb;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    do begin
      @(posedge clk_i);
    end while (!apb_rsp.pready);
    apb_req <= '0;
  endtask

  always @(posedge clk_i) begin : check_rsp
    expect_t               e;
    logic [`L2_DATA_W-1:0] m;
    if (!reset_i && apb_rsp.pready) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected pready at %0t with no transfer in flight", $time);
        other_errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        for (int b = 0; b < `L2_STRB_W; b++) begin
          m[8*b +: 8] = {8{e.known[b]}};
        end
        if (apb_rsp.pslverr !== e.pslverr) begin
          $display("FAIL %0t: addr %h pslverr %b, expected %b",
                   $time, e.addr, apb_rsp.pslverr, e.pslverr);
          slverr_errors++;
        end
        if ((apb_rsp.prdata & m) !== (e.prdata & m)) begin
          $display("FAIL %0t: addr %h prdata %h, expected %h (byte mask %b)",
                   $time, e.addr, apb_rsp.prdata, e.prdata, e.known);
          data_errors++;
        end
      end
    end
  end

  initial begin
    logic [`L2_ROW_W-1:0]  row;
    logic                  bank;
    logic [`L2_ADDR_W-1:0] addr;
    logic [`L2_DATA_W-1:0] data;
    logic [`L2_STRB_W-1:0] strb;
    int                    r;
    int                    total_errors;
    seed    = 32'h2bd0;
    clk_i   = 1'b0;
    reset_i = 1'b1;
    apb_req = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // Quiet bus after reset
    repeat (3) begin
      @(posedge clk_i);
      if (apb_rsp.pready || apb_rsp.pslverr) begin
        $display("FAIL %0t: pready or pslverr high with no transfer", $time);
        other_errors++;
      end
    end

    apb_xfer(interl_addr(1'b0, 9'd3), 1'b1, 32'hcafe_0123, 4'hf);
    apb_xfer(interl_addr(1'b0, 9'd3), 1'b0, '0, '0);

    // Aliases in both directions
    apb_xfer(interl_addr(1'b1, 9'd40), 1'b1, 32'h1234_5678, 4'hf);
    apb_xfer(noninterl_addr(1'b1, 9'd40), 1'b0, '0, '0);
    apb_xfer(noninterl_addr(1'b0, 9'd200), 1'b1, 32'h0bad_f00d, 4'hf);
    apb_xfer(interl_addr(1'b0, 9'd200), 1'b0, '0, '0);

    // Partial strobes, byte offset in the address is ignored
    apb_xfer(interl_addr(1'b1, 9'd7), 1'b1, 32'h1111_1111, 4'hf);
    apb_xfer(interl_addr(1'b1, 9'd7) | 32'h2, 1'b1, 32'haabb_ccdd, 4'b0101);
    apb_xfer(noninterl_addr(1'b1, 9'd7), 1'b0, '0, '0);

    apb_xfer(32'h0000_2000, 1'b0, '0, '0);
    apb_xfer(32'h8000_0010, 1'b1, 32'hffff_ffff, 4'hf);
    foreach (written_q[i]) begin
      apb_xfer(written_q[i], 1'b0, '0, '0);
    end

    // Random mix over a small row range so reads hit earlier writes
    for (int i = 0; i < RANDOM_TXN; i++) begin
      r    = $random(seed);
      bank = r[0];
      row  = {5'd0, r[4:1]};
      if (r[10:8] == 3'd0) begin
        addr = 32'h2000 + ($random(seed) & 32'h0fff_fffc);
      end else if (r[10:8] < 3'd4) begin
        addr = interl_addr(bank, row);
      end else begin
        addr = noninterl_addr(bank, row);
      end
      addr[1:0] = r[13:12];
      data      = $random(seed);
      strb      = r[19:16];
      if (r[20]) begin
        apb_xfer(addr, 1'b1, data, strb);
      end else begin
        apb_xfer(addr, 1'b0, '0, '0);
      end
    end

    repeat (2) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("%0d transfers never completed", exp_q.size());
      other_errors++;
    end
    total_errors = data_errors + slverr_errors + other_errors + dut.u_sva.fail_count;
    $display("checks %0d, data errors %0d, pslverr errors %0d, other errors %0d, sva %0d",
             checks, data_errors, slverr_errors, other_errors, dut.u_sva.fail_count);
    if (total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((TOTAL_TXN * 20 + 100) * 10);
    $display("Timeout: the transfers did not finish in the allowed time");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: files.f
+incdir+.
l2_pkg.sv
l2_apb_frontend.sv
l2_fifo.sv
l2_bank_array.sv
l2_subsys_top.sv
l2_sva.sv
tb_l2_subsys.sv

// File: Bender.yml
package:
  name: l2_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - l2_pkg.sv
      - l2_apb_frontend.sv
      - l2_fifo.sv
      - l2_bank_array.sv
      - l2_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - l2_sva.sv
      - tb_l2_subsys.sv
